// ==== Makefile ====
# Verilator build and run for the execute-stage controller testbench

VERILATOR ?= verilator
TOP       ?= ex_controller_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell grep '\.sv$$' $(FILELIST)) $(wildcard verification/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== src/ex_address_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_address_gen
    import ex_ctrl_pkg::*;
#(
    parameter int W_ADDR_W = 10,
    parameter int D_ADDR_W = 14,
    parameter int CH_W     = 4
)
(
    input  wire                  clk,
    input  wire                  rst,
    input  wire ex_cfg_t         cfg_q,
    input  wire                  job_start,
    input  wire                  loading,
    input  wire loop_status_t    status,
    input  wire [CH_W-1:0]       channel_idx,
    output mem_req_t             mem_req
);

    logic [W_ADDR_W-1:0] w_base;   // first weight of the current filter group
    logic [D_ADDR_W-1:0] d_addr;   // channel * window_size + pixel
    logic [D_ADDR_W-1:0] px_base;  // pixel index of the current read

    ////////////////////////////////////////////////////////////
    // weight side
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            w_base <= '0;
        end
        else if (job_start)
        begin
            w_base <= W_ADDR_W'(cfg_q.w_start_addr);
        end
        else if (status.window_done)
        begin
            w_base <= w_base + W_ADDR_W'(cfg_q.channel_groups);
        end
    end

    ////////////////////////////////////////////////////////////
    // data side, stepping by one window per channel group
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            d_addr  <= '0;
            px_base <= '0;
        end
        else if (job_start)
        begin
            d_addr  <= '0;
            px_base <= '0;
        end
        else if (loading)
        begin
            if (status.window_done)
            begin
                d_addr  <= '0;
                px_base <= '0;
            end
            else if (status.pixel_done)
            begin
                d_addr  <= px_base + D_ADDR_W'(1);   // channel 0 of next pixel
                px_base <= px_base + D_ADDR_W'(1);
            end
            else
            begin
                d_addr <= d_addr + D_ADDR_W'(cfg_q.window_size);
            end
        end
    end

    assign mem_req.weight_addr = w_base + W_ADDR_W'(channel_idx);
    assign mem_req.data_addr   = d_addr;
    assign mem_req.read_en     = loading;

endmodule

`default_nettype wire

// ==== src/ex_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_controller
    import ex_ctrl_pkg::*;
#(
    parameter int W_ADDR_W = 10,
    parameter int D_ADDR_W = 14,
    parameter int CH_W     = 4,
    parameter int FLT_W    = 6,
    parameter int ROW_W    = 7
)
(
    input  wire          clk,
    input  wire          rst,
    input  wire          start,
    input  wire ex_cfg_t cfg,
    output mem_req_t     mem_req,
    output logic         mult_en,
    output logic         zero_fill,
    output logic         done
);

    ex_cfg_t         cfg_q;
    loop_status_t    status;
    logic            job_start;
    logic            loading;
    logic [CH_W-1:0] channel_idx;

    ////////////////////////////////////////////////////////////
    // framing FSM, loop counters, address generation
    ////////////////////////////////////////////////////////////
    ex_row_sequencer i_row_seq (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .cfg       (cfg),
        .status    (status),
        .cfg_q     (cfg_q),
        .job_start (job_start),
        .loading   (loading),
        .mult_en   (mult_en),
        .zero_fill (zero_fill),
        .done      (done)
    );

    ex_loop_counters #(
        .CH_W     (CH_W),
        .D_ADDR_W (D_ADDR_W),
        .ROW_W    (ROW_W),
        .FLT_W    (FLT_W)
    ) i_loops (
        .clk         (clk),
        .rst         (rst),
        .cfg_q       (cfg_q),
        .job_start   (job_start),
        .loading     (loading),
        .status      (status),
        .channel_idx (channel_idx)
    );

    ex_address_gen #(
        .W_ADDR_W (W_ADDR_W),
        .D_ADDR_W (D_ADDR_W),
        .CH_W     (CH_W)
    ) i_addr (
        .clk         (clk),
        .rst         (rst),
        .cfg_q       (cfg_q),
        .job_start   (job_start),
        .loading     (loading),
        .status      (status),
        .channel_idx (channel_idx),
        .mem_req     (mem_req)
    );

endmodule

`default_nettype wire

// ==== src/ex_ctrl_pkg.sv ====
`default_nettype none

package ex_ctrl_pkg;

    ////////////////////////////////////////////////////////////
    // job descriptor, handed over with the start pulse
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [9:0]  w_start_addr;   // first weight word of the layer
        logic [3:0]  channel_groups; // input channels / 16
        logic [5:0]  filter_groups;  // filters / 16
        logic [13:0] window_size;    // pixels per window, up to 112*112
        logic [1:0]  padding;        // 1 to 3 zero cycles per row side
        logic [6:0]  row_size;       // pixels per row, up to 112
    } ex_cfg_t;

    ////////////////////////////////////////////////////////////
    // loop position flags
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic channel_last; // last channel group of the pixel
        logic pixel_done;   // last channel read of a pixel
        logic window_done;  // last read of the window
        logic row_done;     // last read of the row or window
        logic job_done;     // last read of the whole job
    } loop_status_t;

    // read request towards weight and data memories
    typedef struct packed {
        logic [9:0]  weight_addr;
        logic [13:0] data_addr;
        logic        read_en; // one enable serves both memories
    } mem_req_t;

    // row framing FSM
    typedef enum logic [1:0] {
        ST_IDLE      = 2'b00,
        ST_PAD_LEFT  = 2'b01,
        ST_LOAD_ROW  = 2'b10,
        ST_PAD_RIGHT = 2'b11
    } ex_state_e;

endpackage

`default_nettype wire

// ==== src/ex_loop_counters.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_loop_counters
    import ex_ctrl_pkg::*;
#(
    parameter int CH_W     = 4,
    parameter int D_ADDR_W = 14,
    parameter int ROW_W    = 7,
    parameter int FLT_W    = 6
)
(
    input  wire            clk,
    input  wire            rst,
    input  wire ex_cfg_t   cfg_q,
    input  wire            job_start,
    input  wire            loading,
    output loop_status_t   status,
    output logic [CH_W-1:0] channel_idx
);

    logic [CH_W-1:0]     ch_cnt;
    logic [D_ADDR_W-1:0] pix_cnt;  // pixel within the window
    logic [ROW_W-1:0]    row_cnt;  // pixel within the row
    logic [FLT_W-1:0]    flt_cnt;

    logic [CH_W-1:0]     ch_max;
    logic [D_ADDR_W-1:0] pix_max;
    logic [ROW_W-1:0]    row_max;
    logic [FLT_W-1:0]    flt_max;

    assign ch_max  = CH_W'(cfg_q.channel_groups) - CH_W'(1);
    assign pix_max = D_ADDR_W'(cfg_q.window_size) - D_ADDR_W'(1);
    assign row_max = ROW_W'(cfg_q.row_size) - ROW_W'(1);
    assign flt_max = FLT_W'(cfg_q.filter_groups) - FLT_W'(1);

    ////////////////////////////////////////////////////////////
    // end-of-loop flags, purely from the current counts
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        status.channel_last = (ch_cnt == ch_max);
        status.pixel_done   = status.channel_last && loading;
        status.window_done  = status.pixel_done && (pix_cnt == pix_max);
        // a row also ends early where the window runs out
        status.row_done     = (status.pixel_done && (row_cnt == row_max))
                            || status.window_done;
        status.job_done     = status.window_done && (flt_cnt == flt_max);
    end

    assign channel_idx = ch_cnt;

    ////////////////////////////////////////////////////////////
    // counters, all stepping on the same edge
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            ch_cnt  <= '0;
            pix_cnt <= '0;
            row_cnt <= '0;
            flt_cnt <= '0;
        end
        else if (job_start)
        begin
            ch_cnt  <= '0;
            pix_cnt <= '0;
            row_cnt <= '0;
            flt_cnt <= '0;
        end
        else if (loading)
        begin
            // one channel group per read
            if (status.channel_last)
            begin
                ch_cnt <= '0;
            end
            else
            begin
                ch_cnt <= ch_cnt + CH_W'(1);
            end

            if (status.window_done)
            begin
                pix_cnt <= '0;
            end
            else if (status.pixel_done)
            begin
                pix_cnt <= pix_cnt + D_ADDR_W'(1);
            end

            if (status.row_done)
            begin
                row_cnt <= '0;
            end
            else if (status.pixel_done)
            begin
                row_cnt <= row_cnt + ROW_W'(1);
            end

            if (status.job_done)
            begin
                flt_cnt <= '0;
            end
            else if (status.window_done)
            begin
                flt_cnt <= flt_cnt + FLT_W'(1); // next filter group
            end
        end
    end

    a_ch_in_range: assert property (@(posedge clk) disable iff (!rst)
        loading |-> ch_cnt < CH_W'(cfg_q.channel_groups));

endmodule

`default_nettype wire

// ==== src/ex_row_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_row_sequencer
    import ex_ctrl_pkg::*;
(
    input  wire          clk,
    input  wire          rst,
    input  wire          start,
    input  wire ex_cfg_t cfg,
    input  wire loop_status_t status,
    output ex_cfg_t      cfg_q,
    output logic         job_start,
    output logic         loading,
    output logic         mult_en,
    output logic         zero_fill,
    output logic         done
);

    ex_state_e   state_q;
    ex_state_e   state_d;
    logic [1:0]  pad_cnt;
    logic        pad_last;
    logic        padding_st; // either padding state
    logic        take_job;

    // a new job is accepted only while idle
    assign take_job = (state_q == ST_IDLE) && start;

    always_ff @(posedge clk)
    begin
        if (take_job)
        begin
            cfg_q <= cfg;
        end
    end

    ////////////////////////////////////////////////////////////
    // state register and padding counter
    ////////////////////////////////////////////////////////////
    assign padding_st = (state_q == ST_PAD_LEFT) || (state_q == ST_PAD_RIGHT);
    assign pad_last   = (pad_cnt == cfg_q.padding - 2'd1);

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state_q   <= ST_IDLE;
            pad_cnt   <= 2'd0;
            job_start <= 1'b0;
            done      <= 1'b0;
            mult_en   <= 1'b0;
        end
        else
        begin
            state_q   <= state_d;
            job_start <= take_job; // first cycle of the left padding
            done      <= (state_q == ST_LOAD_ROW) && status.job_done;
            mult_en   <= loading;  // multiplier sees data one cycle later
            if (padding_st && !pad_last)
            begin
                pad_cnt <= pad_cnt + 2'd1;
            end
            else
            begin
                pad_cnt <= 2'd0;
            end
        end
    end

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:      if (start) state_d = ST_PAD_LEFT;
            ST_PAD_LEFT:  if (pad_last) state_d = ST_LOAD_ROW;
            ST_LOAD_ROW:
            begin
                if (status.job_done)
                begin
                    state_d = ST_IDLE; // no right padding after the final pixel
                end
                else if (status.row_done)
                begin
                    state_d = ST_PAD_RIGHT;
                end
            end
            ST_PAD_RIGHT: if (pad_last) state_d = ST_PAD_LEFT;
            default:      state_d = ST_IDLE;
        endcase
    end

    assign loading   = (state_q == ST_LOAD_ROW);
    assign zero_fill = padding_st;

    // a padding of zero would give four pad cycles per side
    a_padding_nonzero: assert property (@(posedge clk) disable iff (!rst)
        job_start |-> cfg_q.padding != 2'd0);

    a_done_single: assert property (@(posedge clk) disable iff (!rst)
        done |=> !done);

    a_load_vs_fill: assert property (@(posedge clk) disable iff (!rst)
        !(loading && zero_fill));

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+verification
src/ex_ctrl_pkg.sv
src/ex_row_sequencer.sv
src/ex_loop_counters.sv
src/ex_address_gen.sv
src/ex_controller.sv
verification/ex_controller_tb.sv

// ==== verification/ex_cases.txt ====
# one job per line, all decimal
# w_start channel_groups filter_groups window_size padding row_size reads zero_fill total
0 1 1 1 1 1 1 1 3
16 2 1 4 1 4 8 1 10
100 3 2 6 2 4 36 14 51
1020 4 3 5 3 2 60 51 112
5 15 1 3 1 7 45 1 47
0 2 4 9 2 3 72 46 119
512 1 2 10 3 4 20 33 54
300 5 1 7 1 1 35 13 49
200 5 1 4000 1 100 20000 79 20080
7 3 1 8 2 8 24 2 27
900 1 63 2 3 1 126 753 880
0 1 1 200 2 127 200 6 207

// ==== verification/ex_checks.svh ====
`ifndef EX_CHECKS_SVH
`define EX_CHECKS_SVH

////////////////////////////////////////////////////////////
// failure exit
////////////////////////////////////////////////////////////
task automatic abort_run();
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped at the first error");
endtask

// plain-word failure, no value compare involved
task automatic report_error(input string why);
    $display("%s", why);
    abort_run();
endtask

////////////////////////////////////////////////////////////
// compare tasks
////////////////////////////////////////////////////////////
task automatic check_mem_req(input string name, input mem_req_t act, input mem_req_t exp);
    if (act !== exp)
    begin
        $display("[FAIL] %s weight_addr 0x%h exp 0x%h data_addr 0x%h exp 0x%h",
                 name, act.weight_addr, exp.weight_addr, act.data_addr, exp.data_addr);
        $display("[FAIL] %s read_en 0x%h exp 0x%h at job cycle %0d",
                 name, act.read_en, exp.read_en, cyc);
        abort_run();
    end
endtask

task automatic check_bit(input string name, input logic act, input logic exp);
    if (act !== exp)
    begin
        $display("[FAIL] %s 0x%h exp 0x%h at job cycle %0d", name, act, exp, cyc);
        abort_run();
    end
endtask

task automatic check_count(input string name, input int act, input int exp);
    if (act != exp)
    begin
        $display("[FAIL] %s 0x%h exp 0x%h", name, act, exp);
        abort_run();
    end
endtask

////////////////////////////////////////////////////////////
// waits
////////////////////////////////////////////////////////////
// steps until done shows up, gives up after limit cycles
task automatic wait_for_done(input int limit, output int waited);
    int n;
    bit seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < limit)
    begin
        step_cycle();
        n = n + 1;
        if (done)
        begin
            seen = 1'b1;
        end
    end
    if (!seen)
    begin
        report_error("timed out waiting for done at the end of a job");
    end
    waited = n;
endtask

`endif

// ==== verification/ex_controller_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_controller_tb
    import ex_ctrl_pkg::*;
();

    localparam int W_ADDR_W     = 10;
    localparam int D_ADDR_W     = 14;
    localparam int CH_W         = 4;
    localparam int FLT_W        = 6;
    localparam int ROW_W        = 7;
    localparam int DONE_TIMEOUT = 16;
    localparam int IDLE_CHECKS  = 3;  // idle cycles checked right after reset

    logic     clk;
    logic     rst;
    logic     start;
    ex_cfg_t  cfg;
    mem_req_t mem_req;
    logic     mult_en;
    logic     zero_fill;
    logic     done;

    int       seed;
    int       cyc;          // cycles since start was sampled
    int       poke_cyc;     // cycle of the stray start or 0
    ex_cfg_t  junk_cfg;
    ex_cfg_t  launch_cfg;   // descriptor of the next job
    logic     launch;       // start pulse goes out on the next step
    logic     last_read_en;
    int       n_read;
    int       n_fill;
    int       jobs_run;

    `include "ex_checks.svh"

    ex_controller #(
        .W_ADDR_W (W_ADDR_W),
        .D_ADDR_W (D_ADDR_W),
        .CH_W     (CH_W),
        .FLT_W    (FLT_W),
        .ROW_W    (ROW_W)
    ) i_dut (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .cfg       (cfg),
        .mem_req   (mem_req),
        .mult_en   (mult_en),
        .zero_fill (zero_fill),
        .done      (done)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // one clock of stimulus and sampling
    ////////////////////////////////////////////////////////////
    task automatic step_cycle();
        @(posedge clk);
        cyc = cyc + 1;
        if (launch)
        begin
            start  <= 1'b1;
            cfg    <= launch_cfg;
            launch = 1'b0;
        end
        else if (cyc == poke_cyc)
        begin
            start <= 1'b1;    // stray start while busy
            cfg   <= junk_cfg;
        end
        else
        begin
            start <= 1'b0;
        end
        @(negedge clk);
        check_bit("mult_en", mult_en, last_read_en);
        last_read_en = mem_req.read_en;
        if (mem_req.read_en)
        begin
            n_read = n_read + 1;
        end
        if (zero_fill)
        begin
            n_fill = n_fill + 1;
        end
    endtask

    task automatic expect_idle();
        step_cycle();
        check_bit("read_en", mem_req.read_en, 1'b0);
        check_bit("zero_fill", zero_fill, 1'b0);
        check_bit("done", done, 1'b0);
    endtask

    task automatic expect_pad(input int cycles);
        repeat (cycles)
        begin
            step_cycle();
            check_bit("zero_fill", zero_fill, 1'b1);
            check_bit("read_en", mem_req.read_en, 1'b0);
            check_bit("done", done, 1'b0);
        end
    endtask

    task automatic expect_read(input mem_req_t exp_req);
        step_cycle();
        check_mem_req("mem_req", mem_req, exp_req);
        check_bit("zero_fill", zero_fill, 1'b0);
        check_bit("done", done, 1'b0);
    endtask

    ////////////////////////////////////////////////////////////
    // one job, nested loop reference
    ////////////////////////////////////////////////////////////
    task automatic run_job(input int ws, ch_g, flt_g, win, pad, rs,
                           input int exp_read, exp_fill, exp_total);
        ex_cfg_t  job;
        mem_req_t exp_req;
        int       f;
        int       pix;
        int       p;
        int       ch;
        int       row_len;
        int       waited;
        int       gap;
        job.w_start_addr   = W_ADDR_W'(ws);
        job.channel_groups = CH_W'(ch_g);
        job.filter_groups  = FLT_W'(flt_g);
        job.window_size    = D_ADDR_W'(win);
        job.padding        = 2'(pad);
        job.row_size       = ROW_W'(rs);
        if (exp_total < 3)
        begin
            report_error("case file holds a job shorter than three cycles");
        end
        poke_cyc = 0;
        gap      = 1 + int'({$random(seed)} % 4);
        repeat (gap) expect_idle();

        junk_cfg                = job;
        junk_cfg.w_start_addr   = ~job.w_start_addr;
        junk_cfg.channel_groups = job.channel_groups + 4'd1;
        junk_cfg.padding        = (job.padding == 2'd3) ? 2'd1 : 2'd3;
        poke_cyc = 2 + int'({$random(seed)} % (exp_total - 2)); // never the done cycle

        launch_cfg = job;
        launch     = 1'b1;
        cyc        = -1;
        n_read     = 0;
        n_fill     = 0;
        expect_idle(); // start is high in this cycle

        exp_req.read_en = 1'b1;
        for (f = 0; f < flt_g; f = f + 1)
        begin
            pix = 0;
            while (pix < win)
            begin
                row_len = (rs < win - pix) ? rs : win - pix; // short last row
                expect_pad(pad);
                for (p = 0; p < row_len; p = p + 1)
                begin
                    for (ch = 0; ch < ch_g; ch = ch + 1)
                    begin
                        exp_req.weight_addr = W_ADDR_W'(ws + f * ch_g + ch);
                        exp_req.data_addr   = D_ADDR_W'(ch * win + pix + p);
                        expect_read(exp_req);
                    end
                end
                pix = pix + row_len;
                if (!(f == flt_g - 1 && pix == win))
                begin
                    expect_pad(pad);
                end
            end
        end

        wait_for_done(DONE_TIMEOUT, waited);
        check_count("done_delay", waited, 1);
        check_bit("read_en", mem_req.read_en, 1'b0);
        check_bit("zero_fill", zero_fill, 1'b0);
        check_count("read_cycles", n_read, exp_read);
        check_count("zero_fill_cycles", n_fill, exp_fill);
        check_count("total_cycles", cyc, exp_total);
        poke_cyc = 0;
        expect_idle(); // done is one cycle wide
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////
    initial
    begin
        int    fd;
        int    n;
        string line;
        int    ws, ch_g, flt_g, win, pad, rs;
        int    e_read, e_fill, e_total;
        rst          = 1'b0;
        start        = 1'b0;
        cfg          = '0;
        cyc          = 0;
        poke_cyc     = 0;
        junk_cfg     = '0;
        launch_cfg   = '0;
        launch       = 1'b0;
        last_read_en = 1'b0;
        n_read       = 0;
        n_fill       = 0;
        jobs_run     = 0;
        seed         = 32'h0062f5a7;

        repeat (4) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        check_bit("read_en", mem_req.read_en, 1'b0);
        check_bit("mult_en", mult_en, 1'b0);
        check_bit("zero_fill", zero_fill, 1'b0);
        check_bit("done", done, 1'b0);
        repeat (IDLE_CHECKS) expect_idle();

        fd = $fopen("verification/ex_cases.txt", "r");
        if (fd == 0)
        begin
            report_error("cannot open the case file verification/ex_cases.txt");
        end
        while (!$feof(fd))
        begin
            n = $fgets(line, fd);
            if (n > 0 && line.getc(0) != "#")
            begin
                n = $sscanf(line, "%d %d %d %d %d %d %d %d %d",
                            ws, ch_g, flt_g, win, pad, rs, e_read, e_fill, e_total);
                if (n == 9)
                begin
                    run_job(ws, ch_g, flt_g, win, pad, rs, e_read, e_fill, e_total);
                    jobs_run = jobs_run + 1;
                end
            end
        end
        $fclose(fd);

        if (jobs_run == 0)
        begin
            report_error("no jobs found in the case file");
        end
        else
        begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire
